// File: bench/tb_pitaya_core.sv
//----------------------------------------------------------
// pitaya core testbench
// LFSR driven ADC pins and bus accesses, checked against
// a reference model of conversion and saturation
//----------------------------------------------------------

`timescale 1ns/1ps

module tb_pitaya_core;

  import pitaya_pkg::*;

  localparam int TIMEOUT = 20;                      // cycles per wait loop

  logic                         adc_clk;
  logic                         arst_n_i;
  logic [ADC_PIN_HI:ADC_PIN_LO] adc_dat_a_i;
  logic [ADC_PIN_HI:ADC_PIN_LO] adc_dat_b_i;
  logic [BUS_AW-1:0]            sys_addr_i;
  bus_data_t                    sys_wdata_i;
  logic                         sys_wen_i;
  logic                         sys_ren_i;
  bus_data_t                    sys_rdata_o;
  logic                         sys_ack_o;
  logic                         sys_err_o;
  logic [ADC_W-1:0]             dac_dat_o;
  logic                         dac_sel_o;
  logic                         dac_wrt_o;

  logic [15:0] lfsr;                                // random state
  int          val_errs;                            // wrong values
  int          tmo_errs;                            // missing or late responses

  // reference model state
  logic [ADC_PIN_HI:ADC_PIN_LO] pin_a, pin_b;
  sample_t                      lvl_a, lvl_b;
  logic                         en_a, en_b;
  logic [31:0]                  rnd;
  bus_data_t                    rd;
  sample_t                      exp_a, exp_b;
  region_e                      empty_r [5] = '{REG_HK, REG_AMS, REG_DAISY, REG_FREE, REG_TEST};

  pitaya_core #(.N_REGIONS(8)) u_dut (.*);

  always #4 adc_clk = ~adc_clk;                     // 125 MHz

  //----------------------------------------------------------
  // random source and model
  //----------------------------------------------------------

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);                       // one step per bit
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // negative slope code, all bits but the msb flipped
  function automatic sample_t pins_to_sample(input logic [ADC_PIN_HI:ADC_PIN_LO] p);
    return sample_t'(p ^ 14'h1FFF);
  endfunction

  function automatic sample_t mix_model(input sample_t lvl, input sample_t smp,
                                        input logic en);
    int sum;
    sum = int'(lvl) + (en ? int'(smp) : 0);
    if (sum > int'(SAT_POS)) return SAT_POS;        // clamp high
    if (sum < int'(SAT_NEG)) return SAT_NEG;        // clamp low
    return sample_t'(sum);
  endfunction

  function automatic logic [31:0] reg_addr(input region_e r, input logic [19:0] ofs);
    return {9'b0, r, ofs};
  endfunction

  //----------------------------------------------------------
  // compare tasks
  //----------------------------------------------------------

  task automatic check_sample(input string name, input sample_t exp, input sample_t got);
    if (got !== exp) begin
      $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
      val_errs++;
    end
  endtask

  task automatic check_word(input string name, input bus_data_t exp, input bus_data_t got);
    if (got !== exp) begin
      $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
      val_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("ERR %0t %s exp %b got %b", $time, name, exp, got);
      val_errs++;
    end
  endtask

  //----------------------------------------------------------
  // bus and pin drivers
  //----------------------------------------------------------

  task automatic bus_access(input logic [31:0] addr, input logic wr,
                            input bus_data_t wdata, output bus_data_t rdata);
    int   n;
    logic done;
    @(posedge adc_clk);
    sys_addr_i  <= addr;                            // held until the next access
    sys_wdata_i <= wdata;
    sys_wen_i   <= wr;
    sys_ren_i   <= !wr;
    @(posedge adc_clk);
    sys_wen_i   <= 1'b0;                            // single cycle strobe
    sys_ren_i   <= 1'b0;
    done  = 1'b0;
    n     = 0;
    rdata = '0;
    while (!done && n < TIMEOUT) begin
      @(negedge adc_clk);
      if (sys_ack_o) begin
        done  = 1'b1;
        rdata = sys_rdata_o;
        check_bit("sys_err_o", 1'b0, sys_err_o);
        if (n != 0) begin
          $display("ack for address %h came %0d cycles late", addr, n);
          tmo_errs++;
        end
      end
      n++;
    end
    if (!done) begin
      $display("no ack within %0d cycles for access to address %h", TIMEOUT, addr);
      tmo_errs++;
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input bus_data_t wdata);
    bus_data_t dummy;
    bus_access(addr, 1'b1, wdata, dummy);
  endtask

  task automatic bus_read(input logic [31:0] addr, output bus_data_t rdata);
    bus_access(addr, 1'b0, '0, rdata);
  endtask

  task automatic drive_pins(input logic [ADC_PIN_HI:ADC_PIN_LO] a,
                            input logic [ADC_PIN_HI:ADC_PIN_LO] b);
    @(posedge adc_clk);
    adc_dat_a_i <= a;
    adc_dat_b_i <= b;
  endtask

  task automatic settle();
    repeat (4) @(posedge adc_clk);                  // pipeline is 3 deep
  endtask

  // collect one value per sel phase, decoded back to a sample
  task automatic check_dac(input sample_t ea, input sample_t eb);
    sample_t a, b;
    logic    got_a, got_b;
    logic    prev_sel;
    int      n;
    a        = '0;
    b        = '0;
    got_a    = 1'b0;
    got_b    = 1'b0;
    prev_sel = 1'b0;
    n        = 0;
    while (!(got_a && got_b) && n < TIMEOUT) begin
      @(negedge adc_clk);
      check_bit("dac_wrt_o", 1'b1, dac_wrt_o);
      if (n != 0) check_bit("dac_sel_o", ~prev_sel, dac_sel_o);  // toggles each cycle
      prev_sel = dac_sel_o;
      if (dac_sel_o) begin
        a     = sample_t'(dac_dat_o ^ 14'h1FFF);
        got_a = 1'b1;
      end else begin
        b     = sample_t'(dac_dat_o ^ 14'h1FFF);
        got_b = 1'b1;
      end
      n++;
    end
    if (!(got_a && got_b)) begin
      $display("dac_sel_o did not show both channel phases");
      tmo_errs++;
    end
    check_sample("dac_dat_o ch a", ea, a);
    check_sample("dac_dat_o ch b", eb, b);
  endtask

  //----------------------------------------------------------
  // test sequence
  //----------------------------------------------------------

  initial begin
    adc_clk     = 1'b0;
    arst_n_i    = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    lfsr        = 16'd65;                           // fixed seed
    val_errs    = 0;
    tmo_errs    = 0;
    pin_a       = '0;
    pin_b       = '0;
    lvl_a       = '0;
    lvl_b       = '0;
    en_a        = 1'b0;
    en_b        = 1'b0;
    repeat (3) @(posedge adc_clk);
    arst_n_i <= 1'b1;

    // idle output after reset, pins 0 give full scale but loopback is off
    repeat (2) @(posedge adc_clk);
    check_dac('0, '0);

    // ADC readback through region 1
    for (int i = 0; i < 8; i++) begin
      take_bits(14, rnd);
      pin_a = rnd[13:0];
      take_bits(14, rnd);
      pin_b = rnd[13:0];
      drive_pins(pin_a, pin_b);
      repeat (4) @(posedge adc_clk);
      bus_read(reg_addr(REG_ADC, OFS_CH_A), rd);
      check_word("sys_rdata_o adc a", bus_data_t'(int'(pins_to_sample(pin_a))), rd);
      bus_read(reg_addr(REG_ADC, OFS_CH_B), rd);
      check_word("sys_rdata_o adc b", bus_data_t'(int'(pins_to_sample(pin_b))), rd);
    end

    // levels only, loopback off
    for (int i = 0; i < 8; i++) begin
      take_bits(32, rnd);
      bus_write(reg_addr(REG_GEN, OFS_CH_A), rnd);
      lvl_a = rnd[13:0];                            // upper bits ignored
      take_bits(32, rnd);
      bus_write(reg_addr(REG_GEN, OFS_CH_B), rnd);
      lvl_b = rnd[13:0];
      take_bits(14, rnd);
      pin_a = rnd[13:0];
      take_bits(14, rnd);
      pin_b = rnd[13:0];
      drive_pins(pin_a, pin_b);
      settle();
      check_dac(mix_model(lvl_a, pins_to_sample(pin_a), en_a),
                mix_model(lvl_b, pins_to_sample(pin_b), en_b));
    end

    // loopback on, first two rounds hit both clamps
    bus_write(reg_addr(REG_LOOP, OFS_CH_A), 32'h1);
    bus_write(reg_addr(REG_LOOP, OFS_CH_B), 32'h1);
    en_a = 1'b1;
    en_b = 1'b1;
    for (int i = 0; i < 10; i++) begin
      if (i == 0) begin
        lvl_a = SAT_POS;
        lvl_b = SAT_POS;
      end else if (i == 1) begin
        lvl_a = SAT_NEG;
        lvl_b = SAT_NEG;
      end else begin
        take_bits(14, rnd);
        lvl_a = rnd[13:0];
        take_bits(14, rnd);
        lvl_b = rnd[13:0];
      end
      if (i < 2) begin
        pin_a = lvl_a ^ 14'h1FFF;                   // same extreme on the pins
        pin_b = lvl_b ^ 14'h1FFF;
      end else begin
        take_bits(14, rnd);
        pin_a = rnd[13:0];
        take_bits(14, rnd);
        pin_b = rnd[13:0];
      end
      bus_write(reg_addr(REG_GEN, OFS_CH_A), {18'b0, lvl_a});
      bus_write(reg_addr(REG_GEN, OFS_CH_B), {18'b0, lvl_b});
      drive_pins(pin_a, pin_b);
      settle();
      check_dac(mix_model(lvl_a, pins_to_sample(pin_a), en_a),
                mix_model(lvl_b, pins_to_sample(pin_b), en_b));
    end

    // regions with no block behind them
    exp_a = mix_model(lvl_a, pins_to_sample(pin_a), en_a);
    exp_b = mix_model(lvl_b, pins_to_sample(pin_b), en_b);
    foreach (empty_r[k]) begin
      bus_read(reg_addr(empty_r[k], OFS_CH_A), rd);
      check_word("sys_rdata_o empty region", '0, rd);
      take_bits(32, rnd);
      bus_write(reg_addr(empty_r[k], OFS_CH_B), rnd);
      settle();
      check_dac(exp_a, exp_b);                      // output must not move
    end

    $display("errors: %0d value, %0d timeout", val_errs, tmo_errs);
    if (val_errs == 0 && tmo_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: files.f
hdl/pitaya_pkg.sv
hdl/adc_frontend.sv
hdl/sys_bus_decoder.sv
hdl/ctrl_regs.sv
hdl/dac_mixer.sv
hdl/dac_backend.sv
hdl/pitaya_core.sv
bench/tb_pitaya_core.sv

// File: hdl/adc_frontend.sv
//----------------------------------------------------------
// ADC frontend
// captures both ADC pin buses and turns the unsigned
// negative-slope code into two's complement
//----------------------------------------------------------

`timescale 1ns/1ps

module adc_frontend (
  input  logic                                             adc_clk,
  input  logic                                             arst_n_i,
  input  logic [pitaya_pkg::ADC_PIN_HI:pitaya_pkg::ADC_PIN_LO] adc_dat_a_i,  // CH1 pins
  input  logic [pitaya_pkg::ADC_PIN_HI:pitaya_pkg::ADC_PIN_LO] adc_dat_b_i,  // CH2 pins
  output pitaya_pkg::sample_t                              adc_a_o,
  output pitaya_pkg::sample_t                              adc_b_o
);

  import pitaya_pkg::*;

  sample_t conv_a;  // converted CH1, before the register
  sample_t conv_b;  // converted CH2

  //----------------------------------------------------------
  // code conversion
  //----------------------------------------------------------

  // negative slope: keep msb, flip the rest
  function automatic sample_t pin_to_sample(
    input logic [ADC_PIN_HI:ADC_PIN_LO] pins
  );
    sample_t s;
    s = {pins[ADC_PIN_HI], ~pins[ADC_PIN_HI-1:ADC_PIN_LO]};
    return s;
  endfunction

  assign conv_a = pin_to_sample(adc_dat_a_i);
  assign conv_b = pin_to_sample(adc_dat_b_i);

  //----------------------------------------------------------
  // capture registers
  //----------------------------------------------------------

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= conv_a;  // one cycle from pins
      adc_b_o <= conv_b;
    end
  end

endmodule

// File: hdl/ctrl_regs.sv
//----------------------------------------------------------
// control registers
// per channel output level and loopback enable, plus
// readback of the latest ADC samples
//----------------------------------------------------------

`timescale 1ns/1ps

module ctrl_regs (
  input  logic                                         adc_clk,
  input  logic                                         arst_n_i,
  input  logic [pitaya_pkg::REG_LOOP:pitaya_pkg::REG_ADC] reg_wen_i,
  input  logic [pitaya_pkg::REG_LOOP:pitaya_pkg::REG_ADC] reg_ren_i,
  input  logic [pitaya_pkg::REGION_LO-1:0]             reg_ofs_i,
  input  pitaya_pkg::bus_data_t                        sys_wdata_i,
  input  pitaya_pkg::sample_t                          adc_a_i,
  input  pitaya_pkg::sample_t                          adc_b_i,
  output pitaya_pkg::bus_data_t [pitaya_pkg::REG_LOOP:pitaya_pkg::REG_ADC] reg_rdata_o,
  output logic [pitaya_pkg::REG_LOOP:pitaya_pkg::REG_ADC] reg_ack_o,
  output pitaya_pkg::sample_t                          gen_a_o,
  output pitaya_pkg::sample_t                          gen_b_o,
  output logic                                         loop_en_a_o,
  output logic                                         loop_en_b_o
);

  import pitaya_pkg::*;

  bus_data_t rd_adc;   // region 1 read value
  bus_data_t rd_gen;   // region 2 read value
  bus_data_t rd_loop;  // region 3 read value
  logic      sel_a;    // offset hits channel a
  logic      sel_b;    // offset hits channel b

  function automatic bus_data_t sext(input sample_t s);
    bus_data_t w;
    w = {{(BUS_DW-ADC_W){s[ADC_W-1]}}, s};
    return w;
  endfunction

  assign sel_a = (reg_ofs_i == OFS_CH_A);
  assign sel_b = (reg_ofs_i == OFS_CH_B);

  //----------------------------------------------------------
  // write side
  //----------------------------------------------------------

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gen_a_o     <= '0;
      gen_b_o     <= '0;
      loop_en_a_o <= 1'b0;
      loop_en_b_o <= 1'b0;
    end else begin
      if (reg_wen_i[REG_GEN] && sel_a) gen_a_o <= sys_wdata_i[ADC_W-1:0];  // level a
      if (reg_wen_i[REG_GEN] && sel_b) gen_b_o <= sys_wdata_i[ADC_W-1:0];  // level b
      if (reg_wen_i[REG_LOOP] && sel_a) loop_en_a_o <= sys_wdata_i[0];
      if (reg_wen_i[REG_LOOP] && sel_b) loop_en_b_o <= sys_wdata_i[0];
    end
  end

  //----------------------------------------------------------
  // read side
  //----------------------------------------------------------

  always_comb begin
    rd_adc  = '0;  // unknown offsets read zero
    rd_gen  = '0;
    rd_loop = '0;
    if (sel_a) begin
      rd_adc  = sext(adc_a_i);
      rd_gen  = sext(gen_a_o);
      rd_loop = {{(BUS_DW-1){1'b0}}, loop_en_a_o};
    end else if (sel_b) begin
      rd_adc  = sext(adc_b_i);
      rd_gen  = sext(gen_b_o);
      rd_loop = {{(BUS_DW-1){1'b0}}, loop_en_b_o};
    end
  end

  // read data latched on the strobe, sampled with the ack
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_rdata_o <= '0;
    end else begin
      if (reg_ren_i[REG_ADC])  reg_rdata_o[REG_ADC]  <= rd_adc;
      if (reg_ren_i[REG_GEN])  reg_rdata_o[REG_GEN]  <= rd_gen;
      if (reg_ren_i[REG_LOOP]) reg_rdata_o[REG_LOOP] <= rd_loop;
    end
  end

  // every access acks one cycle later, writes to region 1 are dropped
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_ack_o <= '0;
    end else begin
      reg_ack_o <= reg_wen_i | reg_ren_i;  // single cycle pulse
    end
  end

endmodule

// File: hdl/dac_backend.sv
//----------------------------------------------------------
// DAC backend
// converts both channels to DAC code and interleaves them
// on the shared data bus with select and write strobes
//----------------------------------------------------------

`timescale 1ns/1ps

module dac_backend (
  input  logic                         adc_clk,
  input  logic                         arst_n_i,
  input  pitaya_pkg::sample_t          mix_a_i,
  input  pitaya_pkg::sample_t          mix_b_i,
  output logic [pitaya_pkg::ADC_W-1:0] dac_dat_o,  // combined data
  output logic                         dac_sel_o,  // high while CH1 is on the bus
  output logic                         dac_wrt_o   // DAC write
);

  import pitaya_pkg::*;

  logic             sel_nxt;   // phase for the coming cycle
  logic [ADC_W-1:0] code_a;    // CH1 in DAC code
  logic [ADC_W-1:0] code_b;    // CH2 in DAC code

  // same flip as the ADC side, msb stays
  function automatic logic [ADC_W-1:0] to_dac(input sample_t s);
    logic [ADC_W-1:0] c;
    c = {s[ADC_W-1], ~s[ADC_W-2:0]};
    return c;
  endfunction

  assign code_a  = to_dac(mix_a_i);
  assign code_b  = to_dac(mix_b_i);
  assign sel_nxt = ~dac_sel_o;

  //----------------------------------------------------------
  // interleave
  //----------------------------------------------------------

  // data and select move together, so sel high always shows CH1
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dac_sel_o <= 1'b0;
      dac_wrt_o <= 1'b0;
      dac_dat_o <= to_dac('0);          // midscale, code for 0
    end else begin
      dac_sel_o <= sel_nxt;             // toggles every cycle
      dac_wrt_o <= 1'b1;                // write every cycle once running
      dac_dat_o <= sel_nxt ? code_a : code_b;
    end
  end

endmodule

// File: hdl/dac_mixer.sv
//----------------------------------------------------------
// DAC mixer
// adds output level and looped back ADC sample per channel
// with two's complement saturation
//----------------------------------------------------------

`timescale 1ns/1ps

module dac_mixer (
  input  logic                adc_clk,
  input  logic                arst_n_i,
  input  pitaya_pkg::sample_t adc_a_i,
  input  pitaya_pkg::sample_t adc_b_i,
  input  pitaya_pkg::sample_t gen_a_i,
  input  pitaya_pkg::sample_t gen_b_i,
  input  logic                loop_en_a_i,
  input  logic                loop_en_b_i,
  output pitaya_pkg::sample_t mix_a_o,
  output pitaya_pkg::sample_t mix_b_o
);

  import pitaya_pkg::*;

  sample_t sat_a;  // clamped sum, channel a
  sample_t sat_b;  // clamped sum, channel b

  //----------------------------------------------------------
  // sum and clamp
  //----------------------------------------------------------

  function automatic sample_t sat_add(
    input sample_t lvl,
    input sample_t smp,
    input logic    en
  );
    logic [SUM_W-1:0] sum;
    sample_t          res;
    sum = {lvl[ADC_W-1], lvl} + (en ? {smp[ADC_W-1], smp} : {SUM_W{1'b0}});
    case (sum[SUM_W-1:SUM_W-2])
      2'b01:   res = SAT_POS;           // pos. overflow
      2'b10:   res = SAT_NEG;           // neg. overflow
      default: res = sum[ADC_W-1:0];    // fits in range
    endcase
    return res;
  endfunction

  assign sat_a = sat_add(gen_a_i, adc_a_i, loop_en_a_i);
  assign sat_b = sat_add(gen_b_i, adc_b_i, loop_en_b_i);

  //----------------------------------------------------------
  // output register
  //----------------------------------------------------------

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mix_a_o <= '0;
      mix_b_o <= '0;
    end else begin
      mix_a_o <= sat_a;
      mix_b_o <= sat_b;
    end
  end

endmodule

// File: hdl/pitaya_core.sv
//----------------------------------------------------------
// pitaya core
// ADC capture, register bus with level and loopback control,
// saturating mixer and interleaved DAC output
//----------------------------------------------------------

`timescale 1ns/1ps

module pitaya_core #(
  parameter int N_REGIONS = 8                  // bus regions
) (
  input  logic                                             adc_clk,
  input  logic                                             arst_n_i,

  // ADC
  input  logic [pitaya_pkg::ADC_PIN_HI:pitaya_pkg::ADC_PIN_LO] adc_dat_a_i,  // CH1
  input  logic [pitaya_pkg::ADC_PIN_HI:pitaya_pkg::ADC_PIN_LO] adc_dat_b_i,  // CH2

  // system bus
  input  logic [pitaya_pkg::BUS_AW-1:0]                    sys_addr_i,
  input  pitaya_pkg::bus_data_t                            sys_wdata_i,
  input  logic                                             sys_wen_i,    // write strobe
  input  logic                                             sys_ren_i,    // read strobe
  output pitaya_pkg::bus_data_t                            sys_rdata_o,
  output logic                                             sys_ack_o,
  output logic                                             sys_err_o,

  // DAC
  output logic [pitaya_pkg::ADC_W-1:0]                     dac_dat_o,    // combined data
  output logic                                             dac_sel_o,    // channel select
  output logic                                             dac_wrt_o     // write
);

  import pitaya_pkg::*;

  // data path
  sample_t adc_a;      // CH1 after capture
  sample_t adc_b;      // CH2 after capture
  sample_t gen_a;      // level CH1
  sample_t gen_b;      // level CH2
  logic    loop_en_a;
  logic    loop_en_b;
  sample_t mix_a;      // saturated sum CH1
  sample_t mix_b;      // saturated sum CH2

  // bus between decoder and register block
  logic [REG_LOOP:REG_ADC]      reg_wen;
  logic [REG_LOOP:REG_ADC]      reg_ren;
  logic [REGION_LO-1:0]         reg_ofs;
  bus_data_t [REG_LOOP:REG_ADC] reg_rdata;
  logic [REG_LOOP:REG_ADC]      reg_ack;

  //----------------------------------------------------------
  // input side
  //----------------------------------------------------------

  adc_frontend u_adc_frontend (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  //----------------------------------------------------------
  // bus glue and registers
  //----------------------------------------------------------

  sys_bus_decoder #(
    .N_REGIONS (N_REGIONS)
  ) u_sys_bus_decoder (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .reg_wen_o   (reg_wen),
    .reg_ren_o   (reg_ren),
    .reg_ofs_o   (reg_ofs),
    .reg_rdata_i (reg_rdata),
    .reg_ack_i   (reg_ack),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  ctrl_regs u_ctrl_regs (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .reg_wen_i   (reg_wen),
    .reg_ren_i   (reg_ren),
    .reg_ofs_i   (reg_ofs),
    .sys_wdata_i (sys_wdata_i),
    .adc_a_i     (adc_a),        // readback source
    .adc_b_i     (adc_b),
    .reg_rdata_o (reg_rdata),
    .reg_ack_o   (reg_ack),
    .gen_a_o     (gen_a),
    .gen_b_o     (gen_b),
    .loop_en_a_o (loop_en_a),
    .loop_en_b_o (loop_en_b)
  );

  //----------------------------------------------------------
  // processing
  //----------------------------------------------------------

  dac_mixer u_dac_mixer (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_a_i     (adc_a),
    .adc_b_i     (adc_b),
    .gen_a_i     (gen_a),
    .gen_b_i     (gen_b),
    .loop_en_a_i (loop_en_a),
    .loop_en_b_i (loop_en_b),
    .mix_a_o     (mix_a),
    .mix_b_o     (mix_b)
  );

  //----------------------------------------------------------
  // output side
  //----------------------------------------------------------

  dac_backend u_dac_backend (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .mix_a_i   (mix_a),
    .mix_b_i   (mix_b),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_wrt_o (dac_wrt_o)
  );

endmodule

// File: hdl/pitaya_pkg.sv
//----------------------------------------------------------
// pitaya shared definitions
// sample and bus widths, bus region map, register offsets
// and the DAC saturation limits
//----------------------------------------------------------

package pitaya_pkg;

  // analog sample widths
  localparam int ADC_W      = 14;          // ADC and DAC resolution
  localparam int ADC_PIN_HI = 15;          // top pin bit of ADC bus
  localparam int ADC_PIN_LO = 2;           // bottom pin bit of ADC bus
  localparam int SUM_W      = ADC_W + 1;   // one guard bit for the mixer

  typedef logic signed [ADC_W-1:0] sample_t;  // two's complement sample

  // system bus
  localparam int BUS_AW = 32;
  localparam int BUS_DW = 32;

  typedef logic [BUS_DW-1:0] bus_data_t;

  localparam int REGION_HI = 22;           // region field in address
  localparam int REGION_LO = 20;

  // address regions, 1MB each
  typedef enum logic [2:0] {
    REG_HK    = 3'd0,                      // housekeeping, unmapped
    REG_ADC   = 3'd1,                      // ADC sample readback
    REG_GEN   = 3'd2,                      // output level
    REG_LOOP  = 3'd3,                      // loopback enable
    REG_AMS   = 3'd4,
    REG_DAISY = 3'd5,
    REG_FREE  = 3'd6,
    REG_TEST  = 3'd7
  } region_e;

  // register offsets inside a region
  localparam logic [REGION_LO-1:0] OFS_CH_A = 'h0;
  localparam logic [REGION_LO-1:0] OFS_CH_B = 'h4;

  // clamp values for the DAC sum
  localparam sample_t SAT_POS = 14'h1FFF;  // most positive
  localparam sample_t SAT_NEG = 14'h2000;  // most negative

endpackage

// File: hdl/sys_bus_decoder.sv
//----------------------------------------------------------
// system bus decoder
// splits the address space into regions, steers the strobes
// and returns read data and ack from the selected region
//----------------------------------------------------------

`timescale 1ns/1ps

module sys_bus_decoder #(
  parameter int N_REGIONS = 8                 // regions in the address map
) (
  input  logic                                         adc_clk,
  input  logic                                         arst_n_i,
  input  logic [pitaya_pkg::BUS_AW-1:0]                sys_addr_i,
  input  logic                                         sys_wen_i,
  input  logic                                         sys_ren_i,
  output logic [pitaya_pkg::REG_LOOP:pitaya_pkg::REG_ADC] reg_wen_o,  // mapped regions
  output logic [pitaya_pkg::REG_LOOP:pitaya_pkg::REG_ADC] reg_ren_o,
  output logic [pitaya_pkg::REGION_LO-1:0]             reg_ofs_o,    // offset in region
  input  pitaya_pkg::bus_data_t [pitaya_pkg::REG_LOOP:pitaya_pkg::REG_ADC] reg_rdata_i,
  input  logic [pitaya_pkg::REG_LOOP:pitaya_pkg::REG_ADC] reg_ack_i,
  output pitaya_pkg::bus_data_t                        sys_rdata_o,
  output logic                                         sys_ack_o,
  output logic                                         sys_err_o
);

  import pitaya_pkg::*;

  region_e              region;     // decoded region field
  logic [N_REGIONS-1:0] region_cs;  // one-hot region select
  logic                 free_sel;   // no block behind this region
  logic                 free_ack;   // local ack for empty regions

  //----------------------------------------------------------
  // region decode
  //----------------------------------------------------------

  assign region    = region_e'(sys_addr_i[REGION_HI:REGION_LO]);
  assign reg_ofs_o = sys_addr_i[REGION_LO-1:0];  // low bits go to the block

  always_comb begin
    region_cs         = '0;
    region_cs[region] = 1'b1;
  end

  assign free_sel  = ~|region_cs[REG_LOOP:REG_ADC];  // 0, 4..7 answer locally
  assign reg_wen_o = region_cs[REG_LOOP:REG_ADC] & {(REG_LOOP-REG_ADC+1){sys_wen_i}};
  assign reg_ren_o = region_cs[REG_LOOP:REG_ADC] & {(REG_LOOP-REG_ADC+1){sys_ren_i}};

  // empty regions ack one cycle after the strobe, like the blocks do
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      free_ack <= 1'b0;
    end else begin
      free_ack <= free_sel & (sys_wen_i | sys_ren_i);
    end
  end

  //----------------------------------------------------------
  // return path
  //----------------------------------------------------------

  // address is held until ack, so the current select picks the source
  always_comb begin
    sys_rdata_o = '0;                 // empty regions read zero
    sys_ack_o   = free_sel & free_ack;
    for (int r = REG_ADC; r <= REG_LOOP; r++) begin
      if (region_cs[r]) begin
        sys_rdata_o = reg_rdata_i[r];
        sys_ack_o   = reg_ack_i[r];
      end
    end
  end

  assign sys_err_o = 1'b0;  // no access is refused

endmodule
